/* Bender.yml */
package:
  name: csr_mgr_axil

sources:
  - design/csr_pkg.sv
  - design/axil_skid_buffer.sv
  - design/axil_write_port.sv
  - design/axil_read_port.sv
  - design/csr_regfile.sv
  - design/csr_mgr_axil.sv
  - target: simulation
    files:
      - sim/tb_csr_mgr_axil.sv

/* design/axil_read_port.sv */
//****************************************
// Issues one CSR read at a time from the AR channel
// Registers the R response and holds it until accepted
//****************************************
`timescale 1ns/1ps
`default_nettype none

module axil_read_port
(
    input  wire logic                clk,
    input  wire logic                reset_n,

    input  wire logic                ar_valid,
    output logic                     ar_ready,
    input  wire csr_pkg::axil_ar_t   ar,

    output logic                     r_valid,
    input  wire logic                r_ready,
    output csr_pkg::axil_r_t         r,

    output logic                          csr_rd,
    output logic [csr_pkg::CSR_ADDR_WIDTH-1:0] csr_rd_addr,
    output csr_pkg::csr_tid_t             csr_rd_tid,

    input  wire logic                          rd_valid,
    input  wire logic [csr_pkg::DATA_WIDTH-1:0] rd_data,
    input  wire csr_pkg::csr_tid_t             rd_tid
);

    // Set from issue until the response is taken
    logic busy;
    logic do_read;
    logic r_accept;

    assign ar_ready = !busy;
    assign do_read = ar_valid && !busy;
    assign r_accept = r_valid && r_ready;

    // Read request toward the register file
    assign csr_rd = do_read;
    assign csr_rd_addr = ar.addr[csr_pkg::ADDR_WIDTH-1:csr_pkg::ADDR_LSB];
    assign csr_rd_tid.id = ar.id;
    assign csr_rd_tid.user = ar.user;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            busy <= 1'b0;
            r_valid <= 1'b0;
        end
        else
        begin
            if (do_read)
                busy <= 1'b1;
            else if (r_accept)
                busy <= 1'b0;

            // Register file answer arrives only while busy
            if (rd_valid)
                r_valid <= 1'b1;
            else if (r_accept)
                r_valid <= 1'b0;
        end
    end

    // Response payload with tag unpacked
    always_ff @(posedge clk)
    begin
        if (rd_valid)
        begin
            r.data <= rd_data;
            r.id <= rd_tid.id;
            r.user <= rd_tid.user;
            r.resp <= csr_pkg::RESP_OKAY;
        end
    end

    // Register file never answers a read that was not issued
    a_no_stray_rd: assert property (@(posedge clk) disable iff (!reset_n)
        rd_valid |-> busy && !r_valid);

endmodule

`default_nettype wire

/* design/axil_skid_buffer.sv */
//****************************************
// Two-entry skid buffer for one valid/ready channel
// The payload type is set per instance
//****************************************
`timescale 1ns/1ps
`default_nettype none

module axil_skid_buffer
#(
    parameter type T = logic
)
(
    input  wire logic clk,
    input  wire logic reset_n,

    input  wire logic in_valid,
    output logic      in_ready,
    input  wire T     in_data,

    output logic      out_valid,
    input  wire logic out_ready,
    output T          out_data
);

    // Main register drives the output
    logic main_valid;
    T     main_data;

    // Skid register catches the beat accepted while main is stalled
    logic skid_valid;
    T     skid_data;

    logic accept;
    logic pop;
    logic main_valid_d;
    logic skid_valid_d;
    logic main_from_skid;
    logic main_from_in;
    logic skid_from_in;

    assign accept = in_valid && in_ready;
    assign pop = main_valid && out_ready;

    assign out_valid = main_valid;
    assign out_data = main_data;

    always_comb
    begin
        main_valid_d = main_valid;
        skid_valid_d = skid_valid;
        main_from_skid = 1'b0;
        main_from_in = 1'b0;
        skid_from_in = 1'b0;

        if (!main_valid || pop)
        begin
            // Main slot frees up, older skid entry goes first
            if (skid_valid)
            begin
                main_valid_d = 1'b1;
                skid_valid_d = 1'b0;
                main_from_skid = 1'b1;
            end
            else
            begin
                main_valid_d = accept;
                main_from_in = accept;
            end
        end
        else if (accept)
        begin
            // Main stalled so park the new beat
            skid_valid_d = 1'b1;
            skid_from_in = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            in_ready <= 1'b1;
        end
        else
        begin
            main_valid <= main_valid_d;
            skid_valid <= skid_valid_d;
            // Registered ready, open while the skid slot is free
            in_ready <= !skid_valid_d;
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (main_from_skid)
            main_data <= skid_data;
        else if (main_from_in)
            main_data <= in_data;

        if (skid_from_in)
            skid_data <= in_data;
    end

    // Output payload holds while stalled
    a_out_stable: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

/* design/axil_write_port.sv */
//****************************************
// Joins AW and W into one CSR write strobe
// Holds the B response until the manager takes it
//****************************************
`timescale 1ns/1ps
`default_nettype none

module axil_write_port
(
    input  wire logic                clk,
    input  wire logic                reset_n,

    input  wire logic                aw_valid,
    output logic                     aw_ready,
    input  wire csr_pkg::axil_aw_t   aw,

    input  wire logic                w_valid,
    output logic                     w_ready,
    input  wire csr_pkg::axil_w_t    w,

    output logic                     b_valid,
    input  wire logic                b_ready,
    output csr_pkg::axil_b_t         b,

    output logic                          csr_wr,
    output logic [csr_pkg::CSR_ADDR_WIDTH-1:0] csr_wr_addr,
    output csr_pkg::eng_ctrl_t            csr_wr_data
);

    logic b_slot_free;
    logic do_write;

    // B slot is free when empty or being drained this cycle
    assign b_slot_free = !b_valid || b_ready;

    // Need both halves of the write and room for its response
    assign do_write = aw_valid && w_valid && b_slot_free;

    // Pop AW and W together
    assign aw_ready = do_write;
    assign w_ready = do_write;

    // One-cycle write strobe to the register file
    assign csr_wr = do_write;
    assign csr_wr_addr = aw.addr[csr_pkg::ADDR_WIDTH-1:csr_pkg::ADDR_LSB];
    assign csr_wr_data = w.data;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            b_valid <= 1'b0;
        else if (do_write)
            b_valid <= 1'b1;
        else if (b_ready)
            b_valid <= 1'b0;
    end

    // Response echoes the request tag
    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            b.id <= aw.id;
            b.user <= aw.user;
            b.resp <= csr_pkg::RESP_OKAY;
        end
    end

    a_b_hold: assert property (@(posedge clk) disable iff (!reset_n)
        b_valid && !b_ready |=> b_valid && $stable(b));

endmodule

`default_nettype wire

/* design/csr_mgr_axil.sv */
//****************************************
// AXI-lite CSR manager top level
// Skid buffers feed the write and read ports into the register file
//****************************************
`timescale 1ns/1ps
`default_nettype none

module csr_mgr_axil
#(
    parameter int NUM_ENGINES = 2,
    parameter int INSTANCE_ID = 0,
    parameter int DFH_NEXT_ADDR = 0
)
(
    input  wire logic                 clk,
    input  wire logic                 reset_n,

    // AXI-lite request channels
    input  wire logic                 aw_valid,
    output logic                      aw_ready,
    input  wire csr_pkg::axil_aw_t    aw,
    input  wire logic                 w_valid,
    output logic                      w_ready,
    input  wire csr_pkg::axil_w_t     w,
    input  wire logic                 ar_valid,
    output logic                      ar_ready,
    input  wire csr_pkg::axil_ar_t    ar,

    // AXI-lite response channels
    output logic                      b_valid,
    input  wire logic                 b_ready,
    output csr_pkg::axil_b_t          b,
    output logic                      r_valid,
    input  wire logic                 r_ready,
    output csr_pkg::axil_r_t          r,

    // Engine CSRs
    output csr_pkg::eng_ctrl_t        glob_ctrl,
    output csr_pkg::eng_ctrl_t        eng_ctrl [NUM_ENGINES],
    input  wire csr_pkg::eng_status_t eng_status [NUM_ENGINES]
);

    // Skid buffer outputs
    logic aw_s_valid;
    logic aw_s_ready;
    csr_pkg::axil_aw_t aw_s;
    logic w_s_valid;
    logic w_s_ready;
    csr_pkg::axil_w_t w_s;
    logic ar_s_valid;
    logic ar_s_ready;
    csr_pkg::axil_ar_t ar_s;

    // Register file command and return
    logic csr_wr;
    logic [csr_pkg::CSR_ADDR_WIDTH-1:0] csr_wr_addr;
    csr_pkg::eng_ctrl_t csr_wr_data;
    logic csr_rd;
    logic [csr_pkg::CSR_ADDR_WIDTH-1:0] csr_rd_addr;
    csr_pkg::csr_tid_t csr_rd_tid;
    logic rd_valid;
    logic [csr_pkg::DATA_WIDTH-1:0] rd_data;
    csr_pkg::csr_tid_t rd_tid;

    axil_skid_buffer #(.T(csr_pkg::axil_aw_t)) aw_skid
    (
        .clk, .reset_n,
        .in_valid(aw_valid), .in_ready(aw_ready), .in_data(aw),
        .out_valid(aw_s_valid), .out_ready(aw_s_ready), .out_data(aw_s)
    );

    axil_skid_buffer #(.T(csr_pkg::axil_w_t)) w_skid
    (
        .clk, .reset_n,
        .in_valid(w_valid), .in_ready(w_ready), .in_data(w),
        .out_valid(w_s_valid), .out_ready(w_s_ready), .out_data(w_s)
    );

    axil_skid_buffer #(.T(csr_pkg::axil_ar_t)) ar_skid
    (
        .clk, .reset_n,
        .in_valid(ar_valid), .in_ready(ar_ready), .in_data(ar),
        .out_valid(ar_s_valid), .out_ready(ar_s_ready), .out_data(ar_s)
    );

    axil_write_port axil_write_port_inst
    (
        .clk, .reset_n,
        .aw_valid(aw_s_valid), .aw_ready(aw_s_ready), .aw(aw_s),
        .w_valid(w_s_valid), .w_ready(w_s_ready), .w(w_s),
        .b_valid, .b_ready, .b,
        .csr_wr, .csr_wr_addr, .csr_wr_data
    );

    axil_read_port axil_read_port_inst
    (
        .clk, .reset_n,
        .ar_valid(ar_s_valid), .ar_ready(ar_s_ready), .ar(ar_s),
        .r_valid, .r_ready, .r,
        .csr_rd, .csr_rd_addr, .csr_rd_tid,
        .rd_valid, .rd_data, .rd_tid
    );

    csr_regfile
    #(
        .NUM_ENGINES(NUM_ENGINES),
        .INSTANCE_ID(INSTANCE_ID),
        .DFH_NEXT_ADDR(DFH_NEXT_ADDR)
    )
    csr_regfile_inst
    (
        .clk, .reset_n,
        .csr_wr, .csr_wr_addr, .csr_wr_data,
        .csr_rd, .csr_rd_addr, .csr_rd_tid,
        .rd_valid, .rd_data, .rd_tid,
        .glob_ctrl, .eng_ctrl, .eng_status
    );

endmodule

`default_nettype wire

/* design/csr_pkg.sv */
//****************************************
// Shared widths, AXI-lite channel structs and engine CSR types
// Referenced by scoped name from every design module
//****************************************
`default_nettype none

package csr_pkg;

    // Bus geometry
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 64;
    localparam int ID_WIDTH = 4;
    localparam int USER_WIDTH = 2;

    // CSRs are 8 bytes wide so the low 3 byte address bits are dropped
    localparam int ADDR_LSB = 3;
    localparam int CSR_ADDR_WIDTH = ADDR_WIDTH - ADDR_LSB;

    // Every response is OKAY
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Write address channel payload
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [ID_WIDTH-1:0]   id;
        logic [USER_WIDTH-1:0] user;
    } axil_aw_t;

    // Write data channel payload, full-word writes only
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
    } axil_w_t;

    // Read address channel payload
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [ID_WIDTH-1:0]   id;
        logic [USER_WIDTH-1:0] user;
    } axil_ar_t;

    // Write response payload
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [USER_WIDTH-1:0] user;
        logic [1:0]            resp;
    } axil_b_t;

    // Read response payload
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [ID_WIDTH-1:0]   id;
        logic [USER_WIDTH-1:0] user;
        logic [1:0]            resp;
    } axil_r_t;

    // Read tag carried through the register file alongside the address
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [USER_WIDTH-1:0] user;
    } csr_tid_t;

    // Per-engine control word and status word
    typedef logic [DATA_WIDTH-1:0] eng_ctrl_t;
    typedef logic [DATA_WIDTH-1:0] eng_status_t;

endpackage

`default_nettype wire

/* design/csr_regfile.sv */
//****************************************
// CSR address map with writable storage and a registered read mux
// One-cycle read latency, writes land at the next edge
//****************************************
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
#(
    parameter int NUM_ENGINES = 2,
    parameter int INSTANCE_ID = 0,
    parameter int DFH_NEXT_ADDR = 0
)
(
    input  wire logic                               clk,
    input  wire logic                               reset_n,

    // Write strobe from the write port
    input  wire logic                               csr_wr,
    input  wire logic [csr_pkg::CSR_ADDR_WIDTH-1:0] csr_wr_addr,
    input  wire csr_pkg::eng_ctrl_t                 csr_wr_data,

    // Read request from the read port
    input  wire logic                               csr_rd,
    input  wire logic [csr_pkg::CSR_ADDR_WIDTH-1:0] csr_rd_addr,
    input  wire csr_pkg::csr_tid_t                  csr_rd_tid,

    // Read return one cycle later
    output logic                                    rd_valid,
    output logic [csr_pkg::DATA_WIDTH-1:0]          rd_data,
    output csr_pkg::csr_tid_t                       rd_tid,

    // Engine side
    output csr_pkg::eng_ctrl_t                      glob_ctrl,
    output csr_pkg::eng_ctrl_t                      eng_ctrl [NUM_ENGINES],
    input  wire csr_pkg::eng_status_t               eng_status [NUM_ENGINES]
);

    typedef logic [csr_pkg::CSR_ADDR_WIDTH-1:0] csr_addr_t;

    // Word addresses
    localparam csr_addr_t DFH_ADDR = csr_addr_t'(0);
    localparam csr_addr_t SCRATCH_ADDR = csr_addr_t'(1);
    localparam csr_addr_t GLOB_CTRL_ADDR = csr_addr_t'(2);
    localparam int ENG_BASE_ADDR = 8;

    // Feature header
    // Instance in the top 16 bits, next-DFH offset in the low 24
    localparam logic [csr_pkg::DATA_WIDTH-1:0] DFH_WORD =
        {16'(INSTANCE_ID), 24'h0, 24'(DFH_NEXT_ADDR)};

    logic [csr_pkg::DATA_WIDTH-1:0] scratch;
    logic [csr_pkg::DATA_WIDTH-1:0] rd_mux;

    // Engine e sits at word 8 + e
    function automatic csr_addr_t eng_addr(input int e);
        return csr_addr_t'(ENG_BASE_ADDR + e);
    endfunction

    // Write side
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            scratch <= '0;
            glob_ctrl <= '0;
            for (int e = 0; e < NUM_ENGINES; e++)
                eng_ctrl[e] <= '0;
        end
        else if (csr_wr)
        begin
            case (csr_wr_addr)
                SCRATCH_ADDR:   scratch <= csr_wr_data;
                GLOB_CTRL_ADDR: glob_ctrl <= csr_wr_data;
                default:        ;
            endcase

            // Engine control words, unmapped addresses fall through
            for (int e = 0; e < NUM_ENGINES; e++)
            begin
                if (csr_wr_addr == eng_addr(e))
                    eng_ctrl[e] <= csr_wr_data;
            end
        end
    end

    // Read mux
    // Engine slots read status, not the control word
    always_comb
    begin
        rd_mux = '0;
        case (csr_rd_addr)
            DFH_ADDR:       rd_mux = DFH_WORD;
            SCRATCH_ADDR:   rd_mux = scratch;
            GLOB_CTRL_ADDR: rd_mux = glob_ctrl;
            default:        ;
        endcase

        for (int e = 0; e < NUM_ENGINES; e++)
        begin
            if (csr_rd_addr == eng_addr(e))
                rd_mux = eng_status[e];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rd_valid <= 1'b0;
        else
            rd_valid <= csr_rd;
    end

    // Data and tag follow the request by one cycle
    always_ff @(posedge clk)
    begin
        if (csr_rd)
        begin
            rd_data <= rd_mux;
            rd_tid <= csr_rd_tid;
        end
    end

endmodule

`default_nettype wire

/* sim/tb_csr_mgr_axil.sv */
//****************************************
// Table-driven testbench for the AXI-lite CSR manager
// Runs write/read entries and checks B, R and the engine outputs
//****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_csr_mgr_axil;

    localparam int NUM_ENG = 2;
    localparam logic [15:0] INST_ID = 16'h0005;
    localparam logic [23:0] NEXT_ADDR = 24'h001000;

    // DFH word with instance 5 in bits 63:48 and next offset 0x1000 in bits 23:0
    localparam logic [63:0] DFH_EXP = 64'h0005_0000_0000_1000;

    // Fixed engine status words with index 0 on the right
    localparam logic [NUM_ENG-1:0][63:0] STATUS = {64'he1e1_0000_cafe_0001,
                                                   64'he0e0_0000_beef_0000};

    typedef struct {
        string                    name;
        bit                       is_write;
        logic [15:0]              addr;
        logic [63:0]              data;
        logic [3:0]               id;
        logic [1:0]               user;
        logic [63:0]              exp_data;
        bit                       hold;
        logic [63:0]              exp_glob;
        logic [NUM_ENG-1:0][63:0] exp_eng;
    } entry_t;

    logic clk = 1'b0;
    logic reset_n;

    logic aw_valid;
    logic aw_ready;
    csr_pkg::axil_aw_t aw;
    logic w_valid;
    logic w_ready;
    csr_pkg::axil_w_t w;
    logic ar_valid;
    logic ar_ready;
    csr_pkg::axil_ar_t ar;
    logic b_valid;
    logic b_ready;
    csr_pkg::axil_b_t b;
    logic r_valid;
    logic r_ready;
    csr_pkg::axil_r_t r;
    csr_pkg::eng_ctrl_t glob_ctrl;
    csr_pkg::eng_ctrl_t eng_ctrl [NUM_ENG];
    csr_pkg::eng_status_t eng_status [NUM_ENG];

    entry_t tests[$];
    integer seed;
    int errors;
    int cycles;
    int cycle_limit;

    // Reference state of the writable CSRs while the table is built
    logic [63:0] model_scratch;
    logic [63:0] model_glob;
    logic [NUM_ENG-1:0][63:0] model_eng;

    csr_mgr_axil
    #(
        .NUM_ENGINES(NUM_ENG),
        .INSTANCE_ID(INST_ID),
        .DFH_NEXT_ADDR(NEXT_ADDR)
    )
    csr_mgr_axil_inst
    (
        .clk, .reset_n,
        .aw_valid, .aw_ready, .aw,
        .w_valid, .w_ready, .w,
        .ar_valid, .ar_ready, .ar,
        .b_valid, .b_ready, .b,
        .r_valid, .r_ready, .r,
        .glob_ctrl, .eng_ctrl, .eng_status
    );

    always #5 clk = ~clk;

    // Run limit scales with the table length
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("ERROR: timeout, no response within %0d cycles", cycle_limit);
            $display("errors: %0d", errors + 1);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Address map as seen by a read
    function automatic logic [63:0] expected_read(input logic [15:0] addr);
        logic [12:0] word;
        word = addr[15:3];
        if (word == 0)
            return DFH_EXP;
        if (word == 1)
            return model_scratch;
        if (word == 2)
            return model_glob;
        if (word >= 8 && word < 8 + NUM_ENG)
            return STATUS[word - 8];
        return '0;
    endfunction

    task automatic add_entry(input string name, input bit is_write,
                             input logic [15:0] addr, input bit hold);
        entry_t t;
        logic [12:0] word;
        t.name = name;
        t.is_write = is_write;
        t.addr = addr;
        t.data = {$random(seed), $random(seed)};
        t.id = 4'($random(seed));
        t.user = 2'($random(seed));
        t.hold = hold;
        t.exp_data = expected_read(addr);
        word = addr[15:3];
        if (is_write)
        begin
            // Unmapped and read-only words keep the model as it was
            if (word == 1)
                model_scratch = t.data;
            else if (word == 2)
                model_glob = t.data;
            else if (word >= 8 && word < 8 + NUM_ENG)
                model_eng[word - 8] = t.data;
        end
        t.exp_glob = model_glob;
        t.exp_eng = model_eng;
        tests.push_back(t);
    endtask

    task automatic build_tests();
        model_scratch = '0;
        model_glob = '0;
        model_eng = '0;
        add_entry("dfh_read", 1'b0, 16'h0000, 1'b0);
        add_entry("scratch_write", 1'b1, 16'h0008, 1'b0);
        add_entry("scratch_read", 1'b0, 16'h0008, 1'b0);
        add_entry("glob_write", 1'b1, 16'h0010, 1'b0);
        add_entry("glob_read", 1'b0, 16'h0010, 1'b0);
        add_entry("eng0_write", 1'b1, 16'h0040, 1'b0);
        add_entry("eng1_write", 1'b1, 16'h0048, 1'b0);
        add_entry("eng0_status_read", 1'b0, 16'h0040, 1'b0);
        add_entry("eng1_status_read", 1'b0, 16'h0048, 1'b0);
        add_entry("unmapped_read", 1'b0, 16'h0018, 1'b0);
        add_entry("unmapped_write_hi", 1'b1, 16'h0050, 1'b0);
        add_entry("unmapped_write_lo", 1'b1, 16'h0020, 1'b0);
        add_entry("dfh_write_ignored", 1'b1, 16'h0000, 1'b0);
        add_entry("scratch_read_after", 1'b0, 16'h0008, 1'b0);
        add_entry("scratch_write_hold", 1'b1, 16'h0008, 1'b1);
        add_entry("scratch_read_hold", 1'b0, 16'h0008, 1'b1);
        add_entry("eng1_write_hold", 1'b1, 16'h0048, 1'b1);
        add_entry("unmapped_read_top", 1'b0, 16'hfff8, 1'b0);
        add_entry("dfh_read_again", 1'b0, 16'h0000, 1'b1);
    endtask

    // Waits for B, optionally stalls it, then accepts
    task automatic collect_b(input entry_t t);
        csr_pkg::axil_b_t first;
        int hold_cycles;
        while (!b_valid)
        begin
            @(posedge clk);
            #1;
        end
        first = b;
        hold_cycles = t.hold ? 5 + ($unsigned($random(seed)) % 16) : 0;
        repeat (hold_cycles)
        begin
            @(posedge clk);
            #1;
            if (!b_valid)
            begin
                errors++;
                $display("ERROR: %s b_valid dropped while b_ready was low", t.name);
            end
            check_value({t.name, " held b"}, first, b);
        end
        check_value({t.name, " b.id"}, t.id, b.id);
        check_value({t.name, " b.user"}, t.user, b.user);
        check_value({t.name, " b.resp"}, csr_pkg::RESP_OKAY, b.resp);
        b_ready = 1'b1;
        @(posedge clk);
        #1;
        b_ready = 1'b0;
        // Only one write is outstanding so no further B may follow
        if (b_valid)
        begin
            errors++;
            $display("ERROR: %s a second B response appeared", t.name);
        end
    endtask

    task automatic collect_r(input entry_t t);
        csr_pkg::axil_r_t first;
        int hold_cycles;
        while (!r_valid)
        begin
            @(posedge clk);
            #1;
        end
        first = r;
        hold_cycles = t.hold ? 5 + ($unsigned($random(seed)) % 16) : 0;
        repeat (hold_cycles)
        begin
            @(posedge clk);
            #1;
            if (!r_valid)
            begin
                errors++;
                $display("ERROR: %s r_valid dropped while r_ready was low", t.name);
            end
            check_value({t.name, " held r.data"}, first.data, r.data);
            check_value({t.name, " held r tag"}, {first.id, first.user}, {r.id, r.user});
        end
        check_value({t.name, " r.data"}, t.exp_data, r.data);
        check_value({t.name, " r.id"}, t.id, r.id);
        check_value({t.name, " r.user"}, t.user, r.user);
        check_value({t.name, " r.resp"}, csr_pkg::RESP_OKAY, r.resp);
        r_ready = 1'b1;
        @(posedge clk);
        #1;
        r_ready = 1'b0;
        if (r_valid)
        begin
            errors++;
            $display("ERROR: %s a second R response appeared", t.name);
        end
    endtask

    // AW and W handshake independently with ready sampled before the edge
    task automatic run_write(input entry_t t);
        bit aw_hs;
        bit w_hs;
        aw_valid = 1'b1;
        aw.addr = t.addr;
        aw.id = t.id;
        aw.user = t.user;
        w_valid = 1'b1;
        w.data = t.data;
        while (aw_valid || w_valid)
        begin
            aw_hs = aw_valid && aw_ready;
            w_hs = w_valid && w_ready;
            @(posedge clk);
            #1;
            if (aw_hs)
                aw_valid = 1'b0;
            if (w_hs)
                w_valid = 1'b0;
        end
        collect_b(t);
    endtask

    task automatic run_read(input entry_t t);
        bit ar_hs;
        ar_valid = 1'b1;
        ar.addr = t.addr;
        ar.id = t.id;
        ar.user = t.user;
        ar_hs = 1'b0;
        while (!ar_hs)
        begin
            ar_hs = ar_ready;
            @(posedge clk);
            #1;
        end
        ar_valid = 1'b0;
        collect_r(t);
    endtask

    initial
    begin
        seed = 32'h0abc3905;
        errors = 0;
        cycles = 0;
        reset_n = 1'b0;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        ar_valid = 1'b0;
        b_ready = 1'b0;
        r_ready = 1'b0;
        aw = '0;
        w = '0;
        ar = '0;
        for (int e = 0; e < NUM_ENG; e++)
            eng_status[e] = STATUS[e];
        build_tests();
        cycle_limit = tests.size() * 40 + 200;

        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Outputs straight out of reset
        check_value("reset b_valid", 64'd0, b_valid);
        check_value("reset r_valid", 64'd0, r_valid);
        check_value("reset glob_ctrl", 64'd0, glob_ctrl);
        for (int e = 0; e < NUM_ENG; e++)
            check_value($sformatf("reset eng_ctrl[%0d]", e), 64'd0, eng_ctrl[e]);

        foreach (tests[i])
        begin
            if (tests[i].is_write)
                run_write(tests[i]);
            else
                run_read(tests[i]);
            check_value({tests[i].name, " glob_ctrl"}, tests[i].exp_glob, glob_ctrl);
            for (int e = 0; e < NUM_ENG; e++)
                check_value($sformatf("%s eng_ctrl[%0d]", tests[i].name, e),
                            tests[i].exp_eng[e], eng_ctrl[e]);
        end

        $display("errors: %0d over %0d table entries", errors, tests.size());
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
design/csr_pkg.sv
design/axil_skid_buffer.sv
design/axil_write_port.sv
design/axil_read_port.sv
design/csr_regfile.sv
design/csr_mgr_axil.sv
sim/tb_csr_mgr_axil.sv
